/* logic/glm_config.svh */
`ifndef GLM_CONFIG_SVH
`define GLM_CONFIG_SVH

// Data line carried from region buffer to external memory
`define GLM_LINE_WIDTH 64

// Memory line address
`define GLM_ADDR_WIDTH 32

// Lines per region buffer, as log2
`define GLM_REGION_LOG2_DEPTH 6

// Write FIFO entries in the DMA engine; keep a power of two
`define GLM_WFIFO_DEPTH 8

`endif

/* logic/glm_pkg.sv */
`default_nettype none

`include "glm_config.svh"

package glm_pkg;

    typedef logic [`GLM_LINE_WIDTH-1:0] t_line;           // One cache line of payload

    typedef logic [`GLM_ADDR_WIDTH-1:0] t_claddr;         // Line address in external memory

    typedef logic [`GLM_REGION_LOG2_DEPTH-1:0] t_region_addr; // Line index within a region

endpackage

`default_nettype wire

/* logic/region_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "glm_config.svh"

module region_buffer
(
    input  wire logic                  clk,
    input  wire logic                  reset,

    input  wire logic                  fill_we,
    input  wire glm_pkg::t_region_addr fill_addr,
    input  wire glm_pkg::t_line        fill_data,

    input  wire logic                  rd_en,
    input  wire glm_pkg::t_region_addr rd_addr,
    output logic                       rd_valid,
    output glm_pkg::t_line             rd_data
);

    import glm_pkg::*;

    localparam int DEPTH = 1 << `GLM_REGION_LOG2_DEPTH;

    t_line mem [DEPTH];

    // Host fill and registered read share the array
    always_ff @(posedge clk)
    begin
        if (fill_we)
        begin
            mem[fill_addr] <= fill_data;
        end
        if (rd_en)
        begin
            rd_data <= mem[rd_addr];            // Data one cycle after request
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_valid <= 1'b0;
        end
        else
        begin
            rd_valid <= rd_en;
        end
    end

endmodule

`default_nettype wire

/* logic/region_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module region_reader
(
    input  wire logic                  clk,
    input  wire logic                  reset,

    input  wire logic                  start,
    input  wire glm_pkg::t_region_addr start_line,
    input  wire logic [31:0]           count,
    input  wire logic                  almostfull,

    output logic                       rd_en,
    output glm_pkg::t_region_addr      rd_addr,
    input  wire logic                  rd_valid,
    input  wire glm_pkg::t_line        rd_data,

    output logic                       line_valid,
    output glm_pkg::t_line             line_data
);

    import glm_pkg::*;

    t_region_addr next_addr;
    logic [31:0]  remaining;                     // Lines not yet requested

    // One request per cycle while lines remain and the sink has room
    assign rd_en   = (remaining != 32'd0) && !almostfull;
    assign rd_addr = next_addr;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            remaining <= 32'd0;
        end
        else if (start)
        begin
            remaining <= count;
            next_addr <= start_line;
        end
        else if (rd_en)
        begin
            remaining <= remaining - 32'd1;
            next_addr <= next_addr + 1'b1;       // Wraps inside the region
        end
    end

    // Buffer output is already registered, so forward it as is
    assign line_valid = rd_valid;
    assign line_data  = rd_data;

endmodule

`default_nettype wire

/* logic/glm_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module glm_writeback
(
    input  wire logic                  clk,
    input  wire logic                  reset,

    input  wire logic                  cfg_we,
    input  wire logic [2:0]            cfg_idx,
    input  wire logic [31:0]           cfg_data,

    input  wire logic                  op_start,
    output logic                       op_done,
    input  wire glm_pkg::t_claddr      in_addr,
    input  wire glm_pkg::t_claddr      out_addr,

    output logic                       rd0_start,
    output logic                       rd1_start,
    output glm_pkg::t_region_addr      rd_start_line0,
    output glm_pkg::t_region_addr      rd_start_line1,
    output logic [31:0]                rd_count,
    input  wire logic                  line0_valid,
    input  wire glm_pkg::t_line        line0_data,
    input  wire logic                  line1_valid,
    input  wire glm_pkg::t_line        line1_data,
    output logic                       rd0_almostfull,
    output logic                       rd1_almostfull,

    output logic                       dma_start,
    output glm_pkg::t_claddr           dma_addr,
    output logic [31:0]                dma_length,
    input  wire logic                  dma_idle,
    input  wire logic                  dma_active,
    input  wire logic                  walmostfull,
    input  wire logic                  ack_valid,
    output logic                       wr_en,
    output glm_pkg::t_line             wr_data
);

    import glm_pkg::*;

    typedef enum logic [2:0]
    {
        STATE_IDLE,
        STATE_PREPROCESS,
        STATE_TRIGGER,
        STATE_WRITE,
        STATE_DONE
    } t_writestate;

    t_writestate send_state;

    logic [31:0] cfg_regs [8];
    logic [31:0] offset_by_index [3];
    t_claddr     store_addr;
    logic [31:0] store_length;
    logic [3:0]  select_channel;
    logic        write_fence;
    logic [1:0]  offset_accumulate;
    logic [31:0] num_sent_lines;
    logic [31:0] num_ack_lines;
    logic        use_ch1;
    logic        hold_reader;
    logic        line_valid_q;
    t_line       line_data_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 8; i++)
            begin
                cfg_regs[i] <= 32'd0;
            end
        end
        else if (cfg_we)
        begin
            cfg_regs[cfg_idx] <= cfg_data;
        end
    end

    assign use_ch1 = (select_channel == 4'd1);

    // Reader stalls unless the engine is active, has room and we are writing
    assign hold_reader = walmostfull || !dma_active || (send_state != STATE_WRITE);

    always_ff @(posedge clk)
    begin
        line_valid_q <= use_ch1 ? line1_valid : line0_valid;
        line_data_q  <= use_ch1 ? line1_data : line0_data;
        rd0_almostfull <= hold_reader || use_ch1;
        rd1_almostfull <= hold_reader || !use_ch1;
        if (reset)
        begin
            line_valid_q   <= 1'b0;
            rd0_almostfull <= 1'b1;
            rd1_almostfull <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        dma_start <= 1'b0;
        wr_en     <= 1'b0;
        rd0_start <= 1'b0;
        rd1_start <= 1'b0;
        op_done   <= 1'b0;

        case (send_state)
            STATE_IDLE:
            begin
                if (op_start)
                begin
                    offset_by_index[0] <= cfg_regs[0];
                    offset_by_index[1] <= cfg_regs[1];
                    offset_by_index[2] <= cfg_regs[2];
                    store_addr <= (cfg_regs[3][31] ? in_addr : out_addr)
                                  + t_claddr'(cfg_regs[3][30:0]);
                    store_length   <= cfg_regs[4];
                    select_channel <= cfg_regs[5][3:0];
                    write_fence    <= cfg_regs[5][4];
                    rd_start_line0 <= t_region_addr'(cfg_regs[6]);
                    rd_start_line1 <= t_region_addr'(cfg_regs[7]);
                    offset_accumulate <= 2'd0;
                    num_sent_lines    <= 32'd0;
                    num_ack_lines     <= 32'd0;
                    send_state <= (cfg_regs[4] == 32'd0) ? STATE_DONE : STATE_PREPROCESS;
                end
            end

            STATE_PREPROCESS:
            begin
                store_addr <= store_addr + t_claddr'(offset_by_index[offset_accumulate]);
                offset_accumulate <= offset_accumulate + 2'd1;
                if (offset_accumulate == 2'd2)
                begin
                    send_state <= STATE_TRIGGER;
                end
            end

            STATE_TRIGGER:
            begin
                if (dma_idle)
                begin
                    dma_start  <= 1'b1;
                    dma_addr   <= store_addr;
                    dma_length <= store_length;
                    rd_count   <= store_length;
                    rd0_start  <= !use_ch1;      // Only the chosen region streams
                    rd1_start  <= use_ch1;
                    send_state <= STATE_WRITE;
                end
            end

            STATE_WRITE:
            begin
                if (dma_active && line_valid_q)
                begin
                    wr_en   <= 1'b1;
                    wr_data <= line_data_q;
                    num_sent_lines <= num_sent_lines + 32'd1;
                    if (num_sent_lines == store_length - 32'd1 && !write_fence)
                    begin
                        send_state <= STATE_DONE;
                    end
                end
                if (ack_valid)
                begin
                    num_ack_lines <= num_ack_lines + 32'd1;
                    if (num_ack_lines == store_length - 32'd1 && write_fence)
                    begin
                        send_state <= STATE_DONE;  // Fenced ops wait for the last ack
                    end
                end
            end

            STATE_DONE:
            begin
                op_done    <= 1'b1;
                send_state <= STATE_IDLE;
            end

            default:
            begin
                send_state <= STATE_IDLE;
            end
        endcase

        if (reset)
        begin
            send_state <= STATE_IDLE;
            dma_start  <= 1'b0;
            wr_en      <= 1'b0;
            rd0_start  <= 1'b0;
            rd1_start  <= 1'b0;
            op_done    <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/dma_write_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "glm_config.svh"

module dma_write_engine
(
    input  wire logic                  clk,
    input  wire logic                  reset,

    input  wire logic                  dma_start,
    input  wire glm_pkg::t_claddr      dma_addr,
    input  wire logic [31:0]           dma_length,
    output logic                       dma_idle,
    output logic                       dma_active,
    output logic                       walmostfull,

    input  wire logic                  wr_en,
    input  wire glm_pkg::t_line        wr_data,
    output logic                       ack_valid,

    input  wire logic                  mem_ready,
    output logic                       mem_we,
    output glm_pkg::t_claddr           mem_addr,
    output glm_pkg::t_line             mem_data,
    input  wire logic                  mem_ack
);

    import glm_pkg::*;

    localparam int DEPTH = `GLM_WFIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    t_line            fifo_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   fill_count;
    t_claddr          next_addr;
    logic [31:0]      length_q;
    logic [31:0]      num_written;
    logic [31:0]      num_acked;

    // Margin of four covers the registered flag path back to the reader
    assign walmostfull = (fill_count >= (PTR_W+1)'(DEPTH - 4));
    assign dma_idle    = !dma_active;

    // Drain head of FIFO whenever memory is ready
    assign mem_we   = (fill_count != '0) && mem_ready;
    assign mem_addr = next_addr;
    assign mem_data = fifo_mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            fifo_mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill_count <= '0;
            dma_active <= 1'b0;
            ack_valid  <= 1'b0;
        end
        else
        begin
            ack_valid  <= mem_ack;           // One strobe per acknowledged line
            wr_ptr     <= wr_ptr + PTR_W'(wr_en);
            rd_ptr     <= rd_ptr + PTR_W'(mem_we);
            fill_count <= fill_count + (PTR_W+1)'(wr_en) - (PTR_W+1)'(mem_we);

            if (dma_start && !dma_active)
            begin
                dma_active  <= 1'b1;
                length_q    <= dma_length;
                next_addr   <= dma_addr;
                num_written <= 32'd0;
                num_acked   <= 32'd0;
            end
            else if (dma_active)
            begin
                if (mem_we)
                begin
                    next_addr   <= next_addr + 1'b1;
                    num_written <= num_written + 32'd1;
                end
                if (mem_ack)
                begin
                    num_acked <= num_acked + 32'd1;
                end
                if (num_written == length_q && num_acked == length_q)
                begin
                    dma_active <= 1'b0;      // All lines out and acknowledged
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/glm_writeback_top.sv */
`timescale 1ns/1ps
`default_nettype none

module glm_writeback_top
(
    input  wire logic                  clk,
    input  wire logic                  reset,

    input  wire logic                  cfg_we,
    input  wire logic [2:0]            cfg_idx,
    input  wire logic [31:0]           cfg_data,
    input  wire logic                  op_start,
    output logic                       op_done,
    input  wire glm_pkg::t_claddr      in_addr,
    input  wire glm_pkg::t_claddr      out_addr,

    input  wire logic                  fill_we,
    input  wire logic                  fill_region,
    input  wire glm_pkg::t_region_addr fill_addr,
    input  wire glm_pkg::t_line        fill_data,

    input  wire logic                  mem_ready,
    output logic                       mem_we,
    output glm_pkg::t_claddr           mem_addr,
    output glm_pkg::t_line             mem_data,
    input  wire logic                  mem_ack
);

    import glm_pkg::*;

    logic         rd_start [2];
    t_region_addr rd_start_line [2];
    logic [31:0]  rd_count;
    logic         rd_almostfull [2];
    logic         buf_rd_en [2];
    t_region_addr buf_rd_addr [2];
    logic         buf_rd_valid [2];
    t_line        buf_rd_data [2];
    logic         line_valid [2];
    t_line        line_data [2];

    logic        dma_start;
    t_claddr     dma_addr;
    logic [31:0] dma_length;
    logic        dma_idle;
    logic        dma_active;
    logic        walmostfull;
    logic        ack_valid;
    logic        wr_en;
    t_line       wr_data;

    for (genvar r = 0; r < 2; r++)
    begin : g_region
        region_buffer buffer_i
        (
            .clk       (clk),
            .reset     (reset),
            .fill_we   (fill_we && (fill_region == 1'(r))),  // Per-region fill strobe
            .fill_addr (fill_addr),
            .fill_data (fill_data),
            .rd_en     (buf_rd_en[r]),
            .rd_addr   (buf_rd_addr[r]),
            .rd_valid  (buf_rd_valid[r]),
            .rd_data   (buf_rd_data[r])
        );

        region_reader reader_i
        (
            .clk        (clk),
            .reset      (reset),
            .start      (rd_start[r]),
            .start_line (rd_start_line[r]),
            .count      (rd_count),
            .almostfull (rd_almostfull[r]),
            .rd_en      (buf_rd_en[r]),
            .rd_addr    (buf_rd_addr[r]),
            .rd_valid   (buf_rd_valid[r]),
            .rd_data    (buf_rd_data[r]),
            .line_valid (line_valid[r]),
            .line_data  (line_data[r])
        );
    end

    glm_writeback writeback_i
    (
        .clk            (clk),
        .reset          (reset),
        .cfg_we         (cfg_we),
        .cfg_idx        (cfg_idx),
        .cfg_data       (cfg_data),
        .op_start       (op_start),
        .op_done        (op_done),
        .in_addr        (in_addr),
        .out_addr       (out_addr),
        .rd0_start      (rd_start[0]),
        .rd1_start      (rd_start[1]),
        .rd_start_line0 (rd_start_line[0]),
        .rd_start_line1 (rd_start_line[1]),
        .rd_count       (rd_count),
        .line0_valid    (line_valid[0]),
        .line0_data     (line_data[0]),
        .line1_valid    (line_valid[1]),
        .line1_data     (line_data[1]),
        .rd0_almostfull (rd_almostfull[0]),
        .rd1_almostfull (rd_almostfull[1]),
        .dma_start      (dma_start),
        .dma_addr       (dma_addr),
        .dma_length     (dma_length),
        .dma_idle       (dma_idle),
        .dma_active     (dma_active),
        .walmostfull    (walmostfull),
        .ack_valid      (ack_valid),
        .wr_en          (wr_en),
        .wr_data        (wr_data)
    );

    dma_write_engine engine_i
    (
        .clk         (clk),
        .reset       (reset),
        .dma_start   (dma_start),
        .dma_addr    (dma_addr),
        .dma_length  (dma_length),
        .dma_idle    (dma_idle),
        .dma_active  (dma_active),
        .walmostfull (walmostfull),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .ack_valid   (ack_valid),
        .mem_ready   (mem_ready),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_data    (mem_data),
        .mem_ack     (mem_ack)
    );

endmodule

`default_nettype wire

/* bench/glm_writeback_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module glm_writeback_assertions
(
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             op_done,
    input  wire logic             dma_start,
    input  wire logic             mem_we,
    input  wire glm_pkg::t_claddr mem_addr
);

    import glm_pkg::*;

    logic    seen_write;                         // A line already went out in this DMA run
    t_claddr last_addr;
    int      failures = 0;

    always_ff @(posedge clk)
    begin
        if (reset || dma_start)
        begin
            seen_write <= 1'b0;
        end
        else if (mem_we)
        begin
            seen_write <= 1'b1;
            last_addr  <= mem_addr;
        end
    end

    no_write_in_reset: assert property (@(posedge clk) reset |-> !mem_we)
    else
    begin
        $error("mem_we high while reset is asserted");
        failures++;
    end

    done_single_cycle: assert property (@(posedge clk) disable iff (reset)
                                        op_done |=> !op_done)
    else
    begin
        $error("op_done held for more than one cycle");
        failures++;
    end

    // Burst address steps by one line per write
    addr_increments: assert property (@(posedge clk) disable iff (reset)
                                      (mem_we && seen_write)
                                      |-> mem_addr == t_claddr'(last_addr + 1'b1))
    else
    begin
        $error("mem_addr did not advance by one line between writes");
        failures++;
    end

endmodule

`default_nettype wire

/* bench/glm_writeback_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "glm_config.svh"

module glm_writeback_tb;

    import glm_pkg::*;

    localparam int REGION_DEPTH = 1 << `GLM_REGION_LOG2_DEPTH;
    localparam int LINES_T1     = 20;
    localparam int LINES_T2     = 24;
    localparam int LINES_T3     = 12;
    localparam int LINES_T5     = 40;            // Several times the write FIFO depth
    localparam int LINES_T6     = 16 + 10 + 8;
    localparam int CYCLE_LIMIT  = (LINES_T1 + LINES_T2 + LINES_T3 + LINES_T5 + LINES_T6) * 4
                                  + 2000;

    logic         clk;
    logic         reset;
    logic         cfg_we;
    logic [2:0]   cfg_idx;
    logic [31:0]  cfg_data;
    logic         op_start;
    logic         op_done;
    t_claddr      in_addr;
    t_claddr      out_addr;
    logic         fill_we;
    logic         fill_region;
    t_region_addr fill_addr;
    t_line        fill_data;
    logic         mem_ready;
    logic         mem_we;
    t_claddr      mem_addr;
    t_line        mem_data;
    logic         mem_ack;

    t_line       region_model [2][REGION_DEPTH];
    logic [31:0] cfg_model [8];
    t_claddr     expect_addr [$];
    t_line       expect_data [$];
    t_claddr     ack_queue [$];            // Writes still waiting for their ack
    logic [31:0] rand_state;
    int          ack_wait;
    int          ack_max_delay;
    bit          ready_random;
    int          error_count;
    int          write_count;
    int          done_count;
    int          acks_driven;
    int          checks_done;
    int          cycle_count;
    int          tests_run;
    int          tests_failed;
    int          base_errors;
    int          base_writes;
    int          base_done;

    glm_writeback_top dut_i
    (
        .clk         (clk),
        .reset       (reset),
        .cfg_we      (cfg_we),
        .cfg_idx     (cfg_idx),
        .cfg_data    (cfg_data),
        .op_start    (op_start),
        .op_done     (op_done),
        .in_addr     (in_addr),
        .out_addr    (out_addr),
        .fill_we     (fill_we),
        .fill_region (fill_region),
        .fill_addr   (fill_addr),
        .fill_data   (fill_data),
        .mem_ready   (mem_ready),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_data    (mem_data),
        .mem_ack     (mem_ack)
    );

    bind glm_writeback_top glm_writeback_assertions assertions_i
    (
        .clk       (clk),
        .reset     (reset),
        .op_done   (op_done),
        .dma_start (dma_start),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_count);
        $display("TEST FAILED");
        $finish;
    end

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic int random_below(input int n);
        return int'((next_random() >> 16) % n);  // Upper bits, low LCG bits are weak
    endfunction

    task automatic check_line(input t_claddr exp_addr, input t_line exp_data);
        checks_done++;
        assert (mem_addr == exp_addr)
        else
        begin
            $display("MISMATCH mem_addr: got %h, expected %h", mem_addr, exp_addr);
            error_count++;
        end
        assert (mem_data == exp_data)
        else
        begin
            $display("MISMATCH mem_data: got %h, expected %h", mem_data, exp_data);
            error_count++;
        end
    endtask

    // Memory side observer, write order is the reference order
    always @(posedge clk)
    begin
        if (!reset && op_done)
        begin
            done_count++;
        end
        if (!reset && mem_we)
        begin
            write_count++;
            ack_queue.push_back(mem_addr);
            assert (expect_addr.size() != 0)
            else
            begin
                $display("Memory write to address %h arrived with no line expected", mem_addr);
                error_count++;
            end
            if (expect_addr.size() != 0)
            begin
                check_line(expect_addr.pop_front(), expect_data.pop_front());
            end
        end
    end

    // One clock of stimulus, memory model answers in order
    task automatic run_cycle();
        @(negedge clk);
        mem_ack = 1'b0;
        if (ack_queue.size() != 0)
        begin
            if (ack_wait == 0)
            begin
                void'(ack_queue.pop_front());
                mem_ack = 1'b1;
                acks_driven++;
                ack_wait = random_below(ack_max_delay + 1);
            end
            else
            begin
                ack_wait--;
            end
        end
        mem_ready = ready_random ? (random_below(2) == 1) : 1'b1;
    endtask

    task automatic fill_regions();
        t_line line;
        for (int r = 0; r < 2; r++)
        begin
            for (int a = 0; a < REGION_DEPTH; a++)
            begin
                line = {next_random(), next_random()};
                region_model[r][a] = line;
                fill_we     = 1'b1;
                fill_region = 1'(r);
                fill_addr   = t_region_addr'(a);
                fill_data   = line;
                run_cycle();
            end
        end
        fill_we = 1'b0;
    endtask

    // Program all eight registers and queue the lines this op must write
    task automatic configure_op(input int channel, input bit use_in, input int count,
                                input bit fence);
        t_claddr addr;
        int      start;
        cfg_model[0] = next_random();
        cfg_model[1] = next_random();
        cfg_model[2] = next_random();
        cfg_model[3] = (next_random() >> 1) | (32'(use_in) << 31);
        cfg_model[4] = count;
        cfg_model[5] = (32'(fence) << 4) | 32'(channel);
        cfg_model[6] = random_below(REGION_DEPTH);
        cfg_model[7] = random_below(REGION_DEPTH);
        for (int i = 0; i < 8; i++)
        begin
            cfg_we   = 1'b1;
            cfg_idx  = 3'(i);
            cfg_data = cfg_model[i];
            run_cycle();
        end
        cfg_we = 1'b0;
        addr  = (use_in ? in_addr : out_addr) + (cfg_model[3] & 32'h7fff_ffff)
                + cfg_model[0] + cfg_model[1] + cfg_model[2];
        start = cfg_model[6 + channel];
        for (int k = 0; k < count; k++)
        begin
            expect_addr.push_back(addr + t_claddr'(k));
            expect_data.push_back(region_model[channel][(start + k) % REGION_DEPTH]);
        end
    endtask

    task automatic run_operation(input bit fence, output int latency);
        op_start = 1'b1;
        run_cycle();
        op_start = 1'b0;
        latency  = 1;
        while (!op_done)
        begin
            run_cycle();
            latency++;
        end
        if (fence)
        begin
            assert (expect_addr.size() == 0 && acks_driven == write_count)
            else
            begin
                $display("op_done arrived with %0d lines unwritten and %0d acks outstanding",
                         expect_addr.size(), write_count - acks_driven);
                error_count++;
            end
        end
    endtask

    task automatic begin_test();
        base_errors = error_count;
        base_writes = write_count;
        base_done   = done_count;
    endtask

    task automatic end_test(input string name, input int lines, input int ops);
        int errs;
        while (expect_addr.size() != 0 || ack_queue.size() != 0)
        begin
            run_cycle();
        end
        repeat (8) run_cycle();                 // Extra writes would show up here
        assert (write_count - base_writes == lines)
        else
        begin
            $display("MISMATCH mem_we count: got %h, expected %h",
                     write_count - base_writes, lines);
            error_count++;
        end
        assert (done_count - base_done == ops)
        else
        begin
            $display("MISMATCH op_done count: got %h, expected %h", done_count - base_done, ops);
            error_count++;
        end
        errs = error_count - base_errors;
        tests_run++;
        if (errs == 0)
        begin
            $display("test %0d %s: ok, %0d lines", tests_run, name, lines);
        end
        else
        begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errs);
        end
    endtask

    initial
    begin
        int latency;
        rand_state    = 32'd88;
        reset         = 1'b1;
        cfg_we        = 1'b0;
        cfg_idx       = 3'd0;
        cfg_data      = 32'd0;
        op_start      = 1'b0;
        fill_we       = 1'b0;
        fill_region   = 1'b0;
        fill_addr     = '0;
        fill_data     = '0;
        mem_ready     = 1'b0;
        mem_ack       = 1'b0;
        in_addr       = next_random();
        out_addr      = next_random();
        ack_wait      = 0;
        ack_max_delay = 0;
        ready_random  = 1'b0;
        error_count   = 0;
        write_count   = 0;
        done_count    = 0;
        acks_driven   = 0;
        checks_done   = 0;
        tests_run     = 0;
        tests_failed  = 0;
        @(posedge clk);                         // First of four reset edges
        repeat (4) run_cycle();
        reset = 1'b0;
        fill_regions();

        begin_test();
        configure_op(0, 1'b0, LINES_T1, 1'b0);
        run_operation(1'b0, latency);
        end_test("channel 0 from out_addr", LINES_T1, 1);

        begin_test();
        configure_op(1, 1'b1, LINES_T2, 1'b0);
        run_operation(1'b0, latency);
        end_test("channel 1 from in_addr", LINES_T2, 1);

        begin_test();
        ack_max_delay = 7;                      // Slow memory
        configure_op(0, 1'b0, LINES_T3, 1'b1);
        run_operation(1'b1, latency);
        end_test("fenced with slow acks", LINES_T3, 1);
        ack_max_delay = 0;

        begin_test();
        configure_op(1, 1'b0, 0, 1'b0);
        run_operation(1'b0, latency);
        assert (latency == 2)
        else
        begin
            $display("MISMATCH op_done latency: got %h, expected %h", latency, 2);
            error_count++;
        end
        end_test("zero line count", 0, 1);

        begin_test();
        ready_random = 1'b1;
        configure_op(0, 1'b1, LINES_T5, 1'b0);
        run_operation(1'b0, latency);
        end_test("random mem_ready", LINES_T5, 1);

        begin_test();
        ack_max_delay = 3;
        in_addr  = next_random();
        out_addr = next_random();
        configure_op(1, 1'b0, 16, 1'b0);
        run_operation(1'b0, latency);
        in_addr  = next_random();
        out_addr = next_random();
        configure_op(0, 1'b1, 10, 1'b1);        // Starts while the previous op drains
        run_operation(1'b1, latency);
        configure_op(1, 1'b1, 8, 1'b0);
        run_operation(1'b0, latency);
        end_test("back-to-back reprogrammed", LINES_T6, 3);

        $display("%0d tests, %0d failed, %0d lines checked, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, checks_done, error_count,
                 dut_i.assertions_i.failures);
        if (error_count == 0 && tests_failed == 0 && dut_i.assertions_i.failures == 0)
        begin
            $display("TEST PASSED");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+logic
logic/glm_pkg.sv
logic/region_buffer.sv
logic/region_reader.sv
logic/glm_writeback.sv
logic/dma_write_engine.sv
logic/glm_writeback_top.sv
bench/glm_writeback_assertions.sv
bench/glm_writeback_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= glm_writeback_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST PASSED
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
